/* verilog.f */
hdl/cpu_pkg.sv
hdl/program_counter.sv
hdl/cpu_control.sv
hdl/program_ram.sv
hdl/datapath.sv
hdl/cpu_top.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

/* tb/cpu_tb.sv */
// Testbench for the accumulator CPU
// Program loader, LCG operand source and expected-emit queue
// Five directed tests, watchdog and closing result lines
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int HALT_LIMIT = 100;
    localparam int WATCHDOG_T = 5 * (16 + 2 + 16 * 4) * CLK_PERIOD * 2;

    logic              clk;
    logic              reset;
    prog_wr_t          prog_wr;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] out;
    logic              out_valid;
    logic              halted;

    logic [DATA_W-1:0] prog_img [MEM_DEPTH];
    logic [DATA_W-1:0] expect_q [$];
    logic [DATA_W-1:0] exp_val;
    logic [DATA_W-1:0] val_x;
    logic [DATA_W-1:0] val_y;
    logic [ADDR_W-1:0] saved_pc;
    logic [31:0]       rng;
    int                emit_count;
    int                emit_base;
    int                saved_emits;
    int                test_errors;
    int                passed;
    int                failed;

    cpu_top uut (
        .clk         (clk),
        .reset       (reset),
        .prog_wr_i   (prog_wr),
        .pc_o        (pc),
        .out_o       (out),
        .out_valid_o (out_valid),
        .halted_o    (halted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [DATA_W-1:0] draw_byte();
        rng = lcg_next(rng);
        return rng[23:16];
    endfunction

    function automatic logic [DATA_W-1:0] encode(input opcode_e op,
                                                 input logic [ADDR_W-1:0] addr);
        return {op, addr};
    endfunction

    // Emits are checked against the queue head, sampled mid-cycle
    always @(negedge clk) begin
        if (out_valid) begin
            emit_count++;
            assert (expect_q.size() != 0)
            else begin
                $display("error: time %0t, out_o emitted 0x%02h with nothing expected",
                         $time, out);
                test_errors++;
            end
            if (expect_q.size() != 0) begin
                exp_val = expect_q.pop_front();
                assert (out == exp_val)
                else begin
                    $display("error: time %0t, out_o expected 0x%02h actual 0x%02h",
                             $time, exp_val, out);
                    test_errors++;
                end
            end
        end
    end

    task automatic start_test();
        int i;
        test_errors = 0;
        emit_base   = emit_count;
        expect_q.delete();
        for (i = 0; i < MEM_DEPTH; i++) begin
            prog_img[i] = encode(OP_NOP, 4'd0);
        end
    endtask

    // Program is written while reset is held, then reset stays 2 more cycles
    task automatic load_and_reset();
        int i;
        @(posedge clk);
        reset <= 1'b1;
        for (i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            prog_wr.valid <= 1'b1;
            prog_wr.addr  <= i[ADDR_W-1:0];
            prog_wr.data  <= prog_img[i];
        end
        @(posedge clk);
        prog_wr <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_halt();
        int n;
        n = 0;
        while (!halted && n < HALT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (halted)
        else begin
            $display("error: time %0t, CPU did not halt within %0d cycles", $time, HALT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int emits);
        assert (expect_q.size() == 0 && emit_count - emit_base == emits)
        else begin
            $display("error: time %0t, %s saw %0d emits, %0d expected values left over",
                     $time, name, emit_count - emit_base, expect_q.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    initial begin
        reset       = 1'b1;
        prog_wr     = '0;
        rng         = 32'h2819d637;
        emit_count  = 0;
        test_errors = 0;
        passed      = 0;
        failed      = 0;

        // Sum and difference through a store and reload
        start_test();
        val_x = draw_byte();
        val_y = draw_byte();
        prog_img[0]  = encode(OP_LDA, 4'd12);
        prog_img[1]  = encode(OP_LDB, 4'd13);
        prog_img[2]  = encode(OP_ADD, 4'd0);
        prog_img[3]  = encode(OP_WRT, 4'd14);
        prog_img[4]  = encode(OP_LDA, 4'd14);
        prog_img[5]  = encode(OP_DMA, 4'd0);
        prog_img[6]  = encode(OP_LDA, 4'd12);
        prog_img[7]  = encode(OP_SUB, 4'd0);
        prog_img[8]  = encode(OP_WRT, 4'd14);
        prog_img[9]  = encode(OP_LDA, 4'd14);
        prog_img[10] = encode(OP_DMA, 4'd0);
        prog_img[11] = encode(OP_HLT, 4'd0);
        prog_img[12] = val_x;
        prog_img[13] = val_y;
        expect_q.push_back(8'((val_x + val_y) % 256));
        expect_q.push_back(8'((val_x - val_y + 256) % 256));
        load_and_reset();
        wait_halt();
        finish_test("add_sub", 2);

        // B output with a NOP before the halt
        start_test();
        val_y = draw_byte();
        prog_img[0]  = encode(OP_LDB, 4'd15);
        prog_img[1]  = encode(OP_DMB, 4'd0);
        prog_img[2]  = encode(OP_NOP, 4'd0);
        prog_img[3]  = encode(OP_HLT, 4'd0);
        prog_img[15] = val_y;
        expect_q.push_back(val_y);
        load_and_reset();
        wait_halt();
        finish_test("reg_b_out", 1);

        // Jump skips the DMA of the poison value
        start_test();
        val_x = draw_byte();
        val_y = ~val_x;
        prog_img[0]  = encode(OP_LDA, 4'd13);
        prog_img[1]  = encode(OP_JMP, 4'd3);
        prog_img[2]  = encode(OP_DMA, 4'd0);
        prog_img[3]  = encode(OP_LDA, 4'd14);
        prog_img[4]  = encode(OP_DMA, 4'd0);
        prog_img[5]  = encode(OP_HLT, 4'd0);
        prog_img[13] = val_y;
        prog_img[14] = val_x;
        expect_q.push_back(val_x);
        load_and_reset();
        wait_halt();
        finish_test("jump", 1);

        // Halted CPU stays put
        start_test();
        val_x = draw_byte();
        prog_img[0]  = encode(OP_LDA, 4'd15);
        prog_img[1]  = encode(OP_DMA, 4'd0);
        prog_img[2]  = encode(OP_HLT, 4'd0);
        prog_img[15] = val_x;
        expect_q.push_back(val_x);
        load_and_reset();
        wait_halt();
        saved_pc    = pc;
        saved_emits = emit_count;
        repeat (20) @(negedge clk);
        assert (pc == saved_pc)
        else begin
            $display("error: time %0t, pc_o expected %0d actual %0d", $time, saved_pc, pc);
            test_errors++;
        end
        assert (halted && emit_count == saved_emits)
        else begin
            $display("error: time %0t, halt was left or an emit followed it", $time);
            test_errors++;
        end
        finish_test("halt", 1);

        // Reset after the first emit, then a full rerun
        start_test();
        val_x = draw_byte();
        val_y = draw_byte();
        prog_img[0]  = encode(OP_LDA, 4'd15);
        prog_img[1]  = encode(OP_DMA, 4'd0);
        prog_img[2]  = encode(OP_LDB, 4'd14);
        prog_img[3]  = encode(OP_DMB, 4'd0);
        prog_img[4]  = encode(OP_NOP, 4'd0);
        prog_img[5]  = encode(OP_HLT, 4'd0);
        prog_img[14] = val_y;
        prog_img[15] = val_x;
        expect_q.push_back(val_x);
        expect_q.push_back(val_y);
        load_and_reset();
        while (emit_count == emit_base) begin
            @(negedge clk);
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        expect_q.delete();
        expect_q.push_back(val_x);
        expect_q.push_back(val_y);
        reset <= 1'b0;
        @(negedge clk);
        assert (pc == 0 && !halted)
        else begin
            $display("error: time %0t, pc_o expected 0 actual %0d, halted_o %0b",
                     $time, pc, halted);
            test_errors++;
        end
        wait_halt();
        finish_test("reset_mid_run", 3);

        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passed, failed, uut.u_sva.violations);
        if (failed == 0 && uut.u_sva.violations == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_sva.sv */
// Concurrent checks on the CPU top level ports
// Reset values, single-cycle emit strobe and halt behavior
`default_nettype none

module cpu_sva
    import cpu_pkg::*;
(
    input wire logic              clk,
    input wire logic              reset,
    input wire logic [ADDR_W-1:0] pc_i,
    input wire logic              out_valid_i,
    input wire logic              halted_i
);

    int violations = 0;

    // Status outputs come out of reset low
    reset_clears: assert property (@(posedge clk) reset |=> (!out_valid_i && !halted_i))
    else begin
        $error("out_valid_o or halted_o high in the cycle after reset");
        violations++;
    end

    emit_single: assert property (@(posedge clk) disable iff (reset)
        out_valid_i |=> !out_valid_i)
    else begin
        $error("out_valid_o high for two consecutive cycles");
        violations++;
    end

    // Halt is sticky and freezes the PC
    halt_holds: assert property (@(posedge clk) disable iff (reset)
        halted_i |=> (halted_i && $stable(pc_i)))
    else begin
        $error("halted_o dropped or pc_o moved while halted");
        violations++;
    end

    no_emit_halted: assert property (@(posedge clk) disable iff (reset)
        !(out_valid_i && halted_i))
    else begin
        $error("out_valid_o high while halted_o is high");
        violations++;
    end

endmodule

bind cpu_top cpu_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .pc_i        (pc_o),
    .out_valid_i (out_valid_o),
    .halted_i    (halted_o)
);

`default_nettype wire

/* hdl/cpu_top.sv */
// CPU top level
// Program counter, sequencer, RAM and datapath wired together
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire prog_wr_t          prog_wr_i,
    output logic      [ADDR_W-1:0] pc_o,
    output logic      [DATA_W-1:0] out_o,
    output logic                   out_valid_o,
    output logic                   halted_o
);

    mem_req_t          mem_req;
    dp_ctrl_t          dp_ctrl;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] acc;
    logic              pc_inc;
    logic              pc_load;
    logic [ADDR_W-1:0] jump_target;

    program_counter u_pc (
        .clk      (clk),
        .reset    (reset),
        .inc_i    (pc_inc),
        .load_i   (pc_load),
        .target_i (jump_target),
        .pc_o     (pc_o)
    );

    cpu_control u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .pc_i          (pc_o),
        .rdata_i       (rdata),
        .mem_req_o     (mem_req),
        .dp_ctrl_o     (dp_ctrl),
        .pc_inc_o      (pc_inc),
        .pc_load_o     (pc_load),
        .jump_target_o (jump_target),
        .halted_o      (halted_o)
    );

    // Store data is always the accumulator
    program_ram u_ram (
        .clk       (clk),
        .prog_wr_i (prog_wr_i),
        .mem_req_i (mem_req),
        .wdata_i   (acc),
        .rdata_o   (rdata)
    );

    datapath u_dp (
        .clk         (clk),
        .reset       (reset),
        .ctrl_i      (dp_ctrl),
        .rdata_i     (rdata),
        .acc_o       (acc),
        .out_o       (out_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

/* hdl/datapath.sv */
// Datapath registers and arithmetic
// A, B and accumulator, add/subtract unit, registered data output
`default_nettype none

module datapath
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire dp_ctrl_t          ctrl_i,
    input  wire logic [DATA_W-1:0] rdata_i,
    output logic      [DATA_W-1:0] acc_o,
    output logic      [DATA_W-1:0] out_o,
    output logic                   out_valid_o
);

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] out_q;
    logic              out_valid_q;

    // Results wrap modulo 256
    assign alu_result = ctrl_i.acc_sub ? (reg_a - reg_b) : (reg_a + reg_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= '0;
            reg_b <= '0;
            acc   <= '0;
        end else begin
            if (ctrl_i.load_a) begin
                reg_a <= rdata_i;
            end
            if (ctrl_i.load_b) begin
                reg_b <= rdata_i;
            end
            if (ctrl_i.acc_en) begin
                acc <= alu_result;
            end
        end
    end

    // Output register keeps its value between emits
    always_ff @(posedge clk) begin
        if (reset) begin
            out_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= ctrl_i.emit_a | ctrl_i.emit_b;
            if (ctrl_i.emit_a) begin
                out_q <= reg_a;
            end else if (ctrl_i.emit_b) begin
                out_q <= reg_b;
            end
        end
    end

    assign acc_o       = acc;
    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

/* hdl/program_ram.sv */
// Unified 16 x 8 program and data RAM
// Registered read, program load port and accumulator store port
`default_nettype none

module program_ram
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire prog_wr_t          prog_wr_i,
    input  wire mem_req_t          mem_req_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    output logic      [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] rdata;

    always_ff @(posedge clk) begin
        // Loader wins over a store in the same cycle
        if (prog_wr_i.valid) begin
            mem[prog_wr_i.addr] <= prog_wr_i.data;
        end else if (mem_req_i.we) begin
            mem[mem_req_i.addr] <= wdata_i;
        end
    end

    // Data appears one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[mem_req_i.addr];
    end

    assign rdata_o = rdata;

endmodule

`default_nettype wire

/* hdl/cpu_control.sv */
// Instruction sequencer
// FSM stepping fetch, decode, operand and execute for each instruction
// Instruction register and opcode decode into single-cycle strobes
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [ADDR_W-1:0] pc_i,
    input  wire logic [DATA_W-1:0] rdata_i,
    output mem_req_t               mem_req_o,
    output dp_ctrl_t               dp_ctrl_o,
    output logic                   pc_inc_o,
    output logic                   pc_load_o,
    output logic      [ADDR_W-1:0] jump_target_o,
    output logic                   halted_o
);

    state_e            state;
    state_e            state_next;

    // Instruction register, split into its two nibbles
    opcode_e           ir_op;
    logic [ADDR_W-1:0] ir_operand;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_FETCH;
            ir_op      <= OP_NOP;
            ir_operand <= '0;
        end else begin
            state <= state_next;
            // RAM read issued in fetch is valid during decode
            if (state == S_DECODE) begin
                ir_op      <= opcode_e'(rdata_i[DATA_W-1 -: OP_W]);
                ir_operand <= rdata_i[ADDR_W-1:0];
            end
        end
    end

    always_comb begin
        case (state)
            S_FETCH:   state_next = S_DECODE;
            S_DECODE:  state_next = S_OPERAND;
            S_OPERAND: state_next = S_EXECUTE;
            S_EXECUTE: begin
                if (ir_op == OP_HLT) begin
                    state_next = S_HALT;
                end else begin
                    state_next = S_FETCH;
                end
            end
            S_HALT:    state_next = S_HALT;
            default:   state_next = S_FETCH;
        endcase
    end

    // Instruction address during fetch, operand address otherwise
    always_comb begin
        mem_req_o.addr = (state == S_FETCH) ? pc_i : ir_operand;
        // Store lands in RAM at the end of the operand cycle
        mem_req_o.we   = (state == S_OPERAND) && (ir_op == OP_WRT);
    end

    assign pc_inc_o = (state == S_FETCH);

    // Execute strobes, at most one per instruction
    always_comb begin
        dp_ctrl_o = '0;
        pc_load_o = 1'b0;
        if (state == S_EXECUTE) begin
            case (ir_op)
                OP_LDA: dp_ctrl_o.load_a = 1'b1;
                OP_LDB: dp_ctrl_o.load_b = 1'b1;
                OP_ADD: dp_ctrl_o.acc_en = 1'b1;
                OP_SUB: begin
                    dp_ctrl_o.acc_en  = 1'b1;
                    dp_ctrl_o.acc_sub = 1'b1;
                end
                OP_JMP: pc_load_o        = 1'b1;
                OP_DMA: dp_ctrl_o.emit_a = 1'b1;
                OP_DMB: dp_ctrl_o.emit_b = 1'b1;
                // NOP, HLT, WRT and unknown codes fire nothing here
                default: ;
            endcase
        end
    end

    assign jump_target_o = ir_operand;
    assign halted_o      = (state == S_HALT);

endmodule

`default_nettype wire

/* hdl/program_counter.sv */
// Program counter
// Clears on reset, loads a jump target, otherwise counts up on request
`default_nettype none

module program_counter
    import cpu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              inc_i,
    input  wire logic              load_i,
    input  wire logic [ADDR_W-1:0] target_i,
    output logic      [ADDR_W-1:0] pc_o
);

    logic [ADDR_W-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (load_i) begin
            pc <= target_i;
        end else if (inc_i) begin
            // Wraps from 15 back to 0
            pc <= pc + 1'b1;
        end
    end

    assign pc_o = pc;

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
// Shared definitions for the accumulator CPU
// Widths, opcode and sequencer state enums
// Control structs for RAM access, datapath commands and program load
`default_nettype none

package cpu_pkg;

    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 4;
    localparam int OP_W      = 4;
    localparam int MEM_DEPTH = 16;

    // Upper nibble of an instruction byte
    typedef enum logic [OP_W-1:0] {
        OP_NOP = 4'b0000,
        OP_LDA = 4'b1000,
        OP_LDB = 4'b0100,
        OP_ADD = 4'b0010,
        OP_SUB = 4'b0001,
        OP_JMP = 4'b1001,
        OP_HLT = 4'b1111,
        OP_WRT = 4'b1010,
        OP_DMA = 4'b1011,
        OP_DMB = 4'b1101
    } opcode_e;

    // Four cycles per instruction, plus a terminal halt state
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_OPERAND,
        S_EXECUTE,
        S_HALT
    } state_e;

    // RAM access from the sequencer
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
    } mem_req_t;

    // One-cycle datapath command strobes
    typedef struct packed {
        logic load_a;
        logic load_b;
        logic acc_en;
        logic acc_sub;
        logic emit_a;
        logic emit_b;
    } dp_ctrl_t;

    // Program load write port
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } prog_wr_t;

endpackage

`default_nettype wire
